/* hdl/rv_pkg.sv */
package rv_pkg;

  // architectural sizes
  localparam int xlen     = 32;
  localparam int num_regs = 32;

  // one machine word: register value, immediate, pc or instruction
  typedef logic [xlen-1:0] word_t;

  // index into the integer register file
  typedef logic [4:0] reg_addr_t;

  // pc after reset and per-instruction step
  localparam word_t reset_pc = 32'h0000_0000;
  localparam word_t pc_step  = 32'd4;

  // major opcodes this core executes
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    op_reg = 7'b0110011,
    op_lui = 7'b0110111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    // lui result is just the U immediate
    alu_pass_b = 4'd10
  } alu_op_e;

  // funct7 field values
  localparam logic [6:0] funct7_base = 7'b0000000;
  // sub, sra and srai
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

endpackage

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::word_t     insn,
  output rv_pkg::alu_op_e   alu_op,
  output logic              use_imm,
  output rv_pkg::word_t     imm,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output logic              rd_we,
  output logic              illegal
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;
  logic       alt_ok;
  word_t      imm_i;
  word_t      imm_shamt;
  word_t      imm_u;

  // field split, R-type layout
  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign f7_base = (funct7 == funct7_base);
  assign f7_alt  = (funct7 == funct7_alt);
  // only add/sub and the right shifts have an alternate form
  assign alt_ok  = (funct3 == f3_add_sub) || (funct3 == f3_srl_sra);

  // immediates
  assign imm_i     = {{20{insn[31]}}, insn[31:20]};
  assign imm_shamt = {27'd0, insn[24:20]};
  assign imm_u     = {insn[31:12], 12'd0};

  always_comb begin
    alu_op  = alu_add;
    use_imm = 1'b0;
    imm     = imm_i;
    rd_we   = 1'b0;
    illegal = 1'b0;

    case (opcode)
      op_lui: begin
        alu_op  = alu_pass_b;
        use_imm = 1'b1;
        imm     = imm_u;
        rd_we   = 1'b1;
      end

      op_imm: begin
        use_imm = 1'b1;
        rd_we   = 1'b1;
        case (funct3)
          f3_add_sub: alu_op = alu_add;
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          f3_sll: begin
            alu_op  = alu_sll;
            imm     = imm_shamt;
            illegal = !f7_base;
          end
          f3_srl_sra: begin
            // funct7 sits in the upper immediate bits here
            alu_op  = f7_alt ? alu_sra : alu_srl;
            imm     = imm_shamt;
            illegal = !(f7_base || f7_alt);
          end
        endcase
      end

      op_reg: begin
        rd_we   = 1'b1;
        illegal = !(f7_base || (f7_alt && alt_ok));
        case (funct3)
          f3_add_sub: alu_op = f7_alt ? alu_sub : alu_add;
          f3_sll:     alu_op = alu_sll;
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: alu_op = f7_alt ? alu_sra : alu_srl;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
        endcase
      end

      default: begin
        illegal = 1'b1;
      end
    endcase

    // no register write from a bad encoding
    if (illegal) begin
      rd_we = 1'b0;
    end
  end

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e alu_op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // RV32 shifts only look at five bits
  assign shamt = b[4:0];

  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        // sign bit fills from the left
        result = word_t'($signed(a) >>> shamt);
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_pass_b: begin
        result = b;
      end
      default: begin
        // unused encodings of the 4-bit op field
        result = '0;
      end
    endcase
  end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::reg_addr_t dbg_addr,
  output rv_pkg::word_t     dbg_data
);
  import rv_pkg::*;

  word_t regs [num_regs];

  // all architectural state starts at zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // read ports, no bypass from the write port
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // debug view for the testbench or a debugger
  assign dbg_data = regs[dbg_addr];

  // x0 must survive every write the core attempts
  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    we && (rd == '0) |=> (rs1 == '0 -> rs1_data == '0) && (regs[0] == '0)
  );

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     pc,
  input  rv_pkg::word_t     insn,
  output logic              halt,
  input  rv_pkg::reg_addr_t dbg_addr,
  output rv_pkg::word_t     dbg_data
);
  import rv_pkg::*;

  alu_op_e   alu_op;
  logic      use_imm;
  word_t     imm;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rd_we;
  logic      illegal;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_b;
  word_t     result;
  logic      reg_we;

  rv_decoder u_decoder (
    .insn    (insn),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .imm     (imm),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd_we   (rd_we),
    .illegal (illegal)
  );

  // second operand, register or immediate
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .alu_op (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (result)
  );

  // a halted core leaves the registers alone
  assign reg_we = rd_we && !halt;

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rd       (rd),
    .rd_data  (result),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  // sticky halt, set on the edge that samples the bad word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (illegal) begin
      halt <= 1'b1;
    end
  end

  // pc stays on the illegal instruction
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (!halt && !illegal) begin
      pc <= pc + pc_step;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

  a_pc_frozen: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc));

endmodule

/* include/rv_tb_encode.svh */
`ifndef RV_TB_ENCODE_SVH
`define RV_TB_ENCODE_SVH

// R-type, OP group
function automatic rv_pkg::word_t enc_r(input logic [6:0] funct7,
                                        input rv_pkg::reg_addr_t rs2,
                                        input rv_pkg::reg_addr_t rs1,
                                        input logic [2:0] funct3,
                                        input rv_pkg::reg_addr_t rd);
  return {funct7, rs2, rs1, funct3, rd, rv_pkg::op_reg};
endfunction

// I-type, OP-IMM group with a 12-bit immediate
function automatic rv_pkg::word_t enc_i(input logic [11:0] imm12,
                                        input rv_pkg::reg_addr_t rs1,
                                        input logic [2:0] funct3,
                                        input rv_pkg::reg_addr_t rd);
  return {imm12, rs1, funct3, rd, rv_pkg::op_imm};
endfunction

// immediate shifts, funct7 in the upper immediate bits
function automatic rv_pkg::word_t enc_shift_i(input logic [6:0] funct7,
                                              input logic [4:0] shamt,
                                              input rv_pkg::reg_addr_t rs1,
                                              input logic [2:0] funct3,
                                              input rv_pkg::reg_addr_t rd);
  return {funct7, shamt, rs1, funct3, rd, rv_pkg::op_imm};
endfunction

// U-type, lui only
function automatic rv_pkg::word_t enc_u(input logic [19:0] imm20,
                                        input rv_pkg::reg_addr_t rd);
  return {imm20, rd, rv_pkg::op_lui};
endfunction

// expected result of one ALU operation
function automatic rv_pkg::word_t ref_alu(input rv_pkg::alu_op_e op,
                                          input rv_pkg::word_t a,
                                          input rv_pkg::word_t b);
  case (op)
    rv_pkg::alu_add:    return a + b;
    rv_pkg::alu_sub:    return a - b;
    rv_pkg::alu_sll:    return a << b[4:0];
    rv_pkg::alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    rv_pkg::alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
    rv_pkg::alu_xor:    return a ^ b;
    rv_pkg::alu_srl:    return a >> b[4:0];
    rv_pkg::alu_sra:    return rv_pkg::word_t'($signed(a) >>> b[4:0]);
    rv_pkg::alu_or:     return a | b;
    rv_pkg::alu_and:    return a & b;
    rv_pkg::alu_pass_b: return b;
    default:            return '0;
  endcase
endfunction

`endif

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  `include "rv_tb_encode.svh"

  localparam int max_prog       = 64;
  // resets plus program runs over all tests
  localparam int num_runs       = 14;
  localparam int cycles_per_run = 64;
  localparam int total_cycles   = num_runs * cycles_per_run;

  logic      clk;
  logic      rst;
  word_t     pc;
  word_t     insn;
  logic      halt;
  reg_addr_t dbg_addr;
  word_t     dbg_data;

  word_t prog [max_prog];
  int    prog_len;
  // expected architectural registers
  word_t exp_regs [num_regs];
  int    errors;
  int    checks;

  rv_core DUT (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .insn     (insn),
    .halt     (halt),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // instruction memory, nop past the end of the program
  always @(negedge clk) begin
    if ((pc >> 2) < prog_len) begin
      insn = prog[pc >> 2];
    end else begin
      insn = enc_i(12'd0, 5'd0, f3_add_sub, 5'd0);
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic begin_program();
    prog_len = 0;
    foreach (exp_regs[r]) begin
      exp_regs[r] = '0;
    end
  endtask

  task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // x0 never changes
  task automatic set_expect(input reg_addr_t rd, input word_t v);
    if (rd != 5'd0) begin
      exp_regs[rd] = v;
    end
  endtask

  task automatic emit_lui(input reg_addr_t rd, input logic [19:0] imm20);
    emit(enc_u(imm20, rd));
    set_expect(rd, {imm20, 12'd0});
  endtask

  task automatic emit_imm(input alu_op_e op, input logic [2:0] f3, input reg_addr_t rd,
                          input reg_addr_t rs1, input logic [11:0] imm12);
    emit(enc_i(imm12, rs1, f3, rd));
    set_expect(rd, ref_alu(op, exp_regs[rs1], sext12(imm12)));
  endtask

  task automatic emit_shift(input alu_op_e op, input logic [6:0] f7, input logic [2:0] f3,
                            input reg_addr_t rd, input reg_addr_t rs1, input logic [4:0] shamt);
    emit(enc_shift_i(f7, shamt, rs1, f3, rd));
    set_expect(rd, ref_alu(op, exp_regs[rs1], {27'd0, shamt}));
  endtask

  task automatic emit_reg(input alu_op_e op, input logic [6:0] f7, input logic [2:0] f3,
                          input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    emit(enc_r(f7, rs2, rs1, f3, rd));
    set_expect(rd, ref_alu(op, exp_regs[rs1], exp_regs[rs2]));
  endtask

  // lui rounds up when the low half is negative
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    emit_lui(rd, upper[19:0]);
    emit_imm(alu_add, f3_add_sub, rd, rd, value[11:0]);
  endtask

  task automatic reset_dut();
    @(negedge clk);
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    #2;
  endtask

  // done when pc passes the last word or the core halts
  task automatic run_program(input string name);
    int cycles;
    cycles = 0;
    reset_dut();
    while ((pc != word_t'(prog_len * 4)) && !halt) begin
      @(negedge clk);
      #2;
      cycles++;
      // one instruction per cycle, pc moves one word
      if (!halt) begin
        check_word({name, " pc step"}, word_t'(cycles * 4), pc);
      end
      if (cycles > prog_len + 8) begin
        errors++;
        $display("%s: program did not finish within %0d cycles", name, cycles);
        return;
      end
    end
  endtask

  task automatic read_reg(input reg_addr_t r, output word_t v);
    @(negedge clk);
    dbg_addr = r;
    #2;
    v = dbg_data;
  endtask

  task automatic check_regs(input string name);
    word_t v;
    for (int r = 0; r < num_regs; r++) begin
      read_reg(reg_addr_t'(r), v);
      check_word($sformatf("%s x%0d", name, r), exp_regs[r], v);
    end
  endtask

  task automatic final_check(input string name);
    check_word({name, " pc"}, word_t'(prog_len * 4), pc);
    check_flag({name, " halt"}, 1'b0, halt);
    check_regs(name);
  endtask

  task automatic test_reset();
    begin_program();
    load_const(5'd7, 32'hcafe_f00d);
    run_program("reset");
    // second reset must clear what the program wrote
    begin_program();
    reset_dut();
    check_word("reset pc", reset_pc, pc);
    check_flag("reset halt", 1'b0, halt);
    check_regs("reset");
  endtask

  task automatic test_lui_addi();
    word_t consts [5] = '{32'h1234_5678, 32'hdead_beef, 32'hffff_f800,
                          32'h0000_0fff, 32'h8000_0000};
    begin_program();
    for (int i = 0; i < 5; i++) begin
      load_const(reg_addr_t'(i + 1), consts[i]);
    end
    emit_lui(5'd6, 20'habcde);
    run_program("lui_addi");
    final_check("lui_addi");
  endtask

  task automatic test_op_imm();
    string name;
    for (int round = 0; round < 4; round++) begin
      name = $sformatf("op_imm round %0d", round);
      begin_program();
      load_const(5'd1, $urandom());
      emit_imm(alu_slt, f3_slt, 5'd3, 5'd1, 12'($urandom()));
      emit_imm(alu_sltu, f3_sltu, 5'd4, 5'd1, 12'($urandom()));
      emit_imm(alu_xor, f3_xor, 5'd5, 5'd1, 12'($urandom()));
      emit_imm(alu_or, f3_or, 5'd6, 5'd1, 12'($urandom()));
      emit_imm(alu_and, f3_and, 5'd7, 5'd1, 12'($urandom()));
      emit_shift(alu_sll, funct7_base, f3_sll, 5'd8, 5'd1, 5'($urandom()));
      emit_shift(alu_srl, funct7_base, f3_srl_sra, 5'd9, 5'd1, 5'($urandom()));
      emit_shift(alu_sra, funct7_alt, f3_srl_sra, 5'd10, 5'd1, 5'($urandom()));
      run_program(name);
      final_check(name);
    end
  endtask

  task automatic test_op();
    string name;
    word_t a;
    word_t b;
    for (int round = 0; round < 4; round++) begin
      name = $sformatf("op round %0d", round);
      a = $urandom();
      b = $urandom();
      if (round == 0) begin
        // negative against positive, slt and sltu disagree
        a = a | 32'h8000_0000;
        b = b & 32'h7fff_ffff;
      end
      begin_program();
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit_reg(alu_add, funct7_base, f3_add_sub, 5'd3, 5'd1, 5'd2);
      emit_reg(alu_sub, funct7_alt, f3_add_sub, 5'd4, 5'd1, 5'd2);
      emit_reg(alu_sll, funct7_base, f3_sll, 5'd5, 5'd1, 5'd2);
      emit_reg(alu_slt, funct7_base, f3_slt, 5'd6, 5'd1, 5'd2);
      emit_reg(alu_sltu, funct7_base, f3_sltu, 5'd7, 5'd1, 5'd2);
      emit_reg(alu_xor, funct7_base, f3_xor, 5'd8, 5'd1, 5'd2);
      emit_reg(alu_srl, funct7_base, f3_srl_sra, 5'd9, 5'd1, 5'd2);
      emit_reg(alu_sra, funct7_alt, f3_srl_sra, 5'd10, 5'd1, 5'd2);
      emit_reg(alu_or, funct7_base, f3_or, 5'd11, 5'd1, 5'd2);
      emit_reg(alu_and, funct7_base, f3_and, 5'd12, 5'd1, 5'd2);
      run_program(name);
      final_check(name);
    end
  endtask

  task automatic test_x0();
    begin_program();
    load_const(5'd1, $urandom());
    emit_imm(alu_add, f3_add_sub, 5'd0, 5'd1, 12'h005);
    emit_reg(alu_add, funct7_base, f3_add_sub, 5'd0, 5'd1, 5'd1);
    emit_lui(5'd0, 20'hfffff);
    // x0 as a source after the attempted writes
    emit_reg(alu_add, funct7_base, f3_add_sub, 5'd2, 5'd0, 5'd1);
    emit_imm(alu_or, f3_or, 5'd3, 5'd0, 12'h123);
    run_program("x0");
    final_check("x0");
  endtask

  task automatic test_illegal();
    int bad_idx;
    begin_program();
    load_const(5'd1, 32'h0bad_cafe);
    load_const(5'd2, 32'h1357_9bdf);
    bad_idx = prog_len;
    // sw x1, 0(x2)
    emit({7'd0, 5'd1, 5'd2, 3'b010, 5'd0, 7'b0100011});
    // none of these may execute
    emit(enc_i(12'h7ff, 5'd0, f3_add_sub, 5'd1));
    emit(enc_u(20'h12345, 5'd2));
    emit(enc_r(funct7_base, 5'd2, 5'd1, f3_add_sub, 5'd3));
    run_program("illegal");
    check_flag("illegal halt", 1'b1, halt);
    // pc is frozen, so each following word is fed in at the halted address
    for (int i = 1; i < prog_len - bad_idx; i++) begin
      prog[bad_idx] = prog[bad_idx + i];
      @(negedge clk);
      #2;
      check_word("illegal pc", word_t'(bad_idx * 4), pc);
    end
    check_regs("illegal");
    check_flag("illegal halt held", 1'b1, halt);
    reset_dut();
    check_flag("illegal halt after reset", 1'b0, halt);
    check_word("illegal pc after reset", reset_pc, pc);
  endtask

  initial begin
    int unsigned seed_val;
    rst      = 1'b1;
    insn     = enc_i(12'd0, 5'd0, f3_add_sub, 5'd0);
    dbg_addr = '0;
    errors   = 0;
    checks   = 0;
    prog_len = 0;
    seed_val = $urandom(6);
    test_reset();
    test_lui_addi();
    test_op_imm();
    test_op();
    test_x0();
    test_illegal();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // two times the expected run length
  initial begin
    #(total_cycles * 16);
    $display("watchdog timeout: tests did not complete in %0d cycles", total_cycles * 2);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_core.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_rv_core
RTL_TOP   := rv_core
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only +incdir+include --top-module $(RTL_TOP) \
		hdl/rv_pkg.sv hdl/rv_decoder.sv hdl/rv_alu.sv hdl/rv_regfile.sv hdl/rv_core.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
